// File: files.f
+incdir+test
logic/cpu_pkg.sv
logic/alu.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/processor.sv
test/tb_processor.sv

// File: Makefile
VERILATOR ?= verilator
SIMFLAGS  ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_processor
FILELIST  := files.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// expected register writes in the order writeback sees them
typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] value;
} wb_row_t;

// expected store as word address and data
typedef struct packed {
    logic [31:0] addr;
    logic [31:0] value;
} store_row_t;

// rd = rs op rt and shifts take shamt on rs
function automatic logic [31:0] rtype_word(input int rd, input int rs, input int rt,
                                           input int shamt, input logic [4:0] alu_op);
    return {OP_RTYPE, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], alu_op, 2'b00};
endfunction

// addi, lw, sw, bne, blt and jr share this layout
function automatic logic [31:0] itype_word(input logic [4:0] op, input int rd, input int rs,
                                           input int imm);
    return {op, rd[4:0], rs[4:0], imm[16:0]};
endfunction

function automatic logic [31:0] jump_word(input logic [4:0] op, input int target);
    return {op, target[26:0]};
endfunction

localparam int MARKER = 'hBAD;         // written to r30 only if a squashed slot retires

localparam int PROG_LEN = 33;
localparam logic [31:0] PROG_WORDS [PROG_LEN] = '{
    itype_word(OP_ADDI, 1, 0, 5),               // 0  r1 = 5
    itype_word(OP_ADDI, 2, 1, -3),              // 1  r2 = 2 with r1 from execute
    rtype_word(3, 1, 2, 0, ALU_ADD),            // 2  r3 = 7 from execute and memory
    rtype_word(4, 3, 1, 0, ALU_SUB),            // 3  r4 = 2 with r1 from writeback
    rtype_word(5, 3, 4, 0, ALU_AND),            // 4  r5 = 2
    rtype_word(6, 5, 1, 0, ALU_OR),             // 5  r6 = 7
    rtype_word(7, 6, 0, 4, ALU_SLL),            // 6  r7 = 0x70
    itype_word(OP_ADDI, 8, 0, -256),            // 7  r8 = -256
    rtype_word(9, 8, 0, 4, ALU_SRA),            // 8  r9 = -16
    itype_word(OP_SW, 7, 2, 3),                 // 9  mem[5] = r7
    itype_word(OP_SW, 9, 1, -1),                // 10 mem[4] = r9 via a negative offset
    itype_word(OP_LW, 10, 2, 3),                // 11 r10 = mem[5]
    itype_word(OP_ADDI, 11, 0, 1),              // 12 spacer after the load
    rtype_word(12, 10, 11, 0, ALU_ADD),         // 13 r12 = 0x71 with the loaded word bypassed
    itype_word(OP_BLT, 8, 9, 2),                // 14 -256 < -16 so taken to 17
    itype_word(OP_ADDI, 30, 0, MARKER),         // 15
    itype_word(OP_ADDI, 30, 0, MARKER),         // 16
    itype_word(OP_BLT, 1, 8, 2),                // 17 5 < -256 is false
    itype_word(OP_BNE, 3, 6, 2),                // 18 equal so it falls through
    itype_word(OP_BNE, 12, 1, 2),               // 19 taken to 22
    itype_word(OP_ADDI, 30, 0, MARKER),         // 20
    jump_word(OP_J, 29),                        // 21 fetched as bne resolves, must lose
    jump_word(OP_JAL, 30),                      // 22 r31 = 23
    itype_word(OP_ADDI, 13, 31, 1),             // 23 return point where r13 = 24
    jump_word(OP_J, 27),                        // 24
    itype_word(OP_ADDI, 30, 0, MARKER),         // 25
    itype_word(OP_ADDI, 30, 0, MARKER),         // 26
    itype_word(OP_SW, 13, 0, 0),                // 27 mem[0] = r13
    jump_word(OP_J, 28),                        // 28 spin here
    itype_word(OP_ADDI, 30, 0, MARKER),         // 29
    itype_word(OP_ADDI, 14, 0, 'h7FF),          // 30 subroutine body
    itype_word(OP_JR, 31, 0, 0),                // 31 back to 23
    itype_word(OP_ADDI, 30, 0, MARKER)          // 32
};

localparam int WB_LEN = 15;
localparam wb_row_t WB_TABLE [WB_LEN] = '{
    {5'd1,  32'h0000_0005}, {5'd2,  32'h0000_0002}, {5'd3,  32'h0000_0007},
    {5'd4,  32'h0000_0002}, {5'd5,  32'h0000_0002}, {5'd6,  32'h0000_0007},
    {5'd7,  32'h0000_0070}, {5'd8,  32'hFFFF_FF00}, {5'd9,  32'hFFFF_FFF0},
    {5'd10, 32'h0000_0070}, {5'd11, 32'h0000_0001}, {5'd12, 32'h0000_0071},
    {5'd31, 32'h0000_0017}, {5'd14, 32'h0000_07FF}, {5'd13, 32'h0000_0018}
};

localparam int ST_LEN = 3;
localparam store_row_t ST_TABLE [ST_LEN] = '{
    {32'h0000_0005, 32'h0000_0070},
    {32'h0000_0004, 32'hFFFF_FFF0},
    {32'h0000_0000, 32'h0000_0018}
};

`endif

// File: test/tb_processor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_processor;
    import cpu_pkg::*;

    `include "tb_program.svh"

    localparam int CLK_PERIOD     = 10;
    localparam int MEM_AW         = 6;                       // 64-word memories
    localparam int MEM_WORDS      = 1 << MEM_AW;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 10 + 100;
    localparam int DRAIN_CYCLES   = 20;                      // quiet time after the last event

    logic             clock = 1'b0;
    logic             arst_n;
    logic [XLEN-1:0]  address_imem, q_imem, address_dmem, store_data, q_dmem;
    logic             wren, write_en;
    logic [REG_W-1:0] write_reg, read_reg_a, read_reg_b;
    logic [XLEN-1:0]  write_data, read_data_a, read_data_b;

    logic [XLEN-1:0]  imem [MEM_WORDS];
    logic [XLEN-1:0]  dmem [MEM_WORDS];
    logic [XLEN-1:0]  regs [32];

    int cycle      = 0;                                      // cycles since reset release
    int wb_idx     = 0;
    int st_idx     = 0;
    int mismatches = 0;
    int failures   = 0;

    always #(CLK_PERIOD / 2) clock = ~clock;

    processor i_dut (
        .clock_i (clock), .arst_n_i (arst_n),
        .address_imem_o (address_imem), .q_imem_i (q_imem),
        .address_dmem_o (address_dmem), .data_o (store_data), .wren_o (wren),
        .q_dmem_i (q_dmem),
        .ctrl_writeEnable_o (write_en), .ctrl_writeReg_o (write_reg),
        .data_writeReg_o (write_data),
        .ctrl_readRegA_o (read_reg_a), .ctrl_readRegB_o (read_reg_b),
        .data_readRegA_i (read_data_a), .data_readRegB_i (read_data_b)
    );

    // memories and register file read combinationally
    assign q_imem      = imem[address_imem[MEM_AW-1:0]];
    assign q_dmem      = dmem[address_dmem[MEM_AW-1:0]];
    assign read_data_a = regs[read_reg_a];
    assign read_data_b = regs[read_reg_b];

    always @(posedge clock) begin
        if (wren) dmem[address_dmem[MEM_AW-1:0]] <= store_data;
        if (write_en && write_reg != '0) regs[write_reg] <= write_data;   // r0 stays zero
    end

    task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic expect_writeback();
        assert (wb_idx < WB_LEN) else begin
            $display("register write to r%0d after the last expected writeback", write_reg);
            failures++;
        end
        if (wb_idx < WB_LEN) begin
            if (wb_idx == 0) begin
                assert (cycle == 4) else begin            // fetched in cycle 0, written in 4
                    $display("first register write came in cycle %0d, not in cycle 4", cycle);
                    failures++;
                end
            end
            compare_word("ctrl_writeReg_o", XLEN'(write_reg), XLEN'(WB_TABLE[wb_idx].rd));
            compare_word("data_writeReg_o", write_data, WB_TABLE[wb_idx].value);
            wb_idx++;
        end
    endtask

    task automatic verify_store();
        assert (st_idx < ST_LEN) else begin
            $display("store to address %h after the last expected store", address_dmem);
            failures++;
        end
        if (st_idx < ST_LEN) begin
            compare_word("address_dmem_o", address_dmem, ST_TABLE[st_idx].addr);
            compare_word("data_o", store_data, ST_TABLE[st_idx].value);
            st_idx++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clock) begin
        if (!arst_n) begin
            assert (!write_en && !wren) else begin
                $display("register or memory write enabled during reset");
                failures++;
            end
        end else begin
            if (cycle == 0) compare_word("address_imem_o", address_imem, '0);
            if (write_en) expect_writeback();
            if (wren) verify_store();
            cycle++;
        end
    end

    initial begin
        void'($urandom(32'ha881));
        arst_n = 1'b0;
        for (int i = 0; i < 32; i++) regs[i] <= '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] <= $urandom();
            imem[i] = jump_word(OP_J, i);                  // stray fetches spin in place
        end
        for (int i = 0; i < PROG_LEN; i++) imem[i] = PROG_WORDS[i];
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;
        wait (wb_idx == WB_LEN && st_idx == ST_LEN);
        repeat (DRAIN_CYCLES) @(posedge clock);            // catch late marker writes
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, %0d of %0d writebacks and %0d of %0d stores seen",
                 TIMEOUT_CYCLES, wb_idx, WB_LEN, st_idx, ST_LEN);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/processor.sv
`timescale 1ns/1ps
`default_nettype none

module processor (
    input  logic                      clock_i,
    input  logic                      arst_n_i,
    output logic [cpu_pkg::XLEN-1:0]  address_imem_o,
    input  logic [cpu_pkg::XLEN-1:0]  q_imem_i,
    output logic [cpu_pkg::XLEN-1:0]  address_dmem_o,
    output logic [cpu_pkg::XLEN-1:0]  data_o,
    output logic                      wren_o,
    input  logic [cpu_pkg::XLEN-1:0]  q_dmem_i,
    output logic                      ctrl_writeEnable_o,
    output logic [cpu_pkg::REG_W-1:0] ctrl_writeReg_o,
    output logic [cpu_pkg::XLEN-1:0]  data_writeReg_o,
    output logic [cpu_pkg::REG_W-1:0] ctrl_readRegA_o,
    output logic [cpu_pkg::REG_W-1:0] ctrl_readRegB_o,
    input  logic [cpu_pkg::XLEN-1:0]  data_readRegA_i,
    input  logic [cpu_pkg::XLEN-1:0]  data_readRegB_i
);
    import cpu_pkg::*;

    logic [XLEN-1:0] fd_insn, fd_pc, jr_target, br_target;
    logic            fd_valid, jr_redirect, br_redirect;
    dx_t             dx;
    xm_t             xm;
    fwd_t            x_fwd, m_fwd, w_fwd;

    fetch_stage i_fetch (
        .clock_i, .arst_n_i, .q_imem_i,
        .br_redirect_i (br_redirect), .br_target_i (br_target),
        .jr_redirect_i (jr_redirect), .jr_target_i (jr_target),
        .address_imem_o, .insn_o (fd_insn), .pc_o (fd_pc), .valid_o (fd_valid)
    );

    decode_stage i_decode (
        .clock_i, .arst_n_i, .insn_i (fd_insn), .pc_i (fd_pc), .valid_i (fd_valid),
        .ctrl_readRegA_o, .ctrl_readRegB_o, .data_readRegA_i, .data_readRegB_i,
        .x_fwd_i (x_fwd), .m_fwd_i (m_fwd), .w_fwd_i (w_fwd),
        .br_redirect_i (br_redirect),
        .jr_redirect_o (jr_redirect), .jr_target_o (jr_target), .dx_o (dx)
    );

    execute_stage i_execute (
        .clock_i, .arst_n_i, .dx_i (dx),
        .br_redirect_o (br_redirect), .br_target_o (br_target),
        .x_fwd_o (x_fwd), .xm_o (xm)
    );

    mem_wb_stage i_mem_wb (
        .clock_i, .arst_n_i, .xm_i (xm), .q_dmem_i,
        .address_dmem_o, .data_o, .wren_o,
        .m_fwd_o (m_fwd), .w_fwd_o (w_fwd)
    );

    // registered writeback goes straight to the file
    assign ctrl_writeEnable_o = w_fwd.we;
    assign ctrl_writeReg_o    = w_fwd.rd;
    assign data_writeReg_o    = w_fwd.data;

endmodule

`default_nettype wire

// File: logic/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  logic                     clock_i,
    input  logic                     arst_n_i,
    input  cpu_pkg::xm_t             xm_i,
    input  logic [cpu_pkg::XLEN-1:0] q_dmem_i,
    output logic [cpu_pkg::XLEN-1:0] address_dmem_o,
    output logic [cpu_pkg::XLEN-1:0] data_o,
    output logic                     wren_o,
    output cpu_pkg::fwd_t            m_fwd_o,
    output cpu_pkg::fwd_t            w_fwd_o
);
    import cpu_pkg::*;

    fwd_t m_fwd, w_q;

    // data memory is combinational on the read side
    assign address_dmem_o = xm_i.result;
    assign data_o         = xm_i.store_data;
    assign wren_o         = xm_i.ctrl.valid & xm_i.ctrl.is_sw;

    // loaded word for lw, otherwise whatever execute produced
    assign m_fwd.we   = xm_i.ctrl.valid & xm_i.ctrl.writes_reg;
    assign m_fwd.rd   = xm_i.ctrl.rd;
    assign m_fwd.data = xm_i.ctrl.is_lw ? q_dmem_i : xm_i.result;

    // memory/writeback register, drives the file write ports
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) w_q <= '0;
        else           w_q <= m_fwd;
    end

    assign m_fwd_o = m_fwd;
    assign w_fwd_o = w_q;

    // decode never marks one word as both load and store
    a_lw_sw_exclusive: assert property (@(posedge clock_i) disable iff (!arst_n_i)
        xm_i.ctrl.valid |-> !(xm_i.ctrl.is_lw && xm_i.ctrl.is_sw))
        else $error("memory stage entry is both lw and sw");

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                     clock_i,
    input  logic                     arst_n_i,
    input  cpu_pkg::dx_t             dx_i,
    output logic                     br_redirect_o,
    output logic [cpu_pkg::XLEN-1:0] br_target_o,
    output cpu_pkg::fwd_t            x_fwd_o,
    output cpu_pkg::xm_t             xm_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0] alu_b, alu_val, link_pc, result;
    logic            ne, lt;                     // rd vs rs from the compare alu
    xm_t             xm_d, xm_q;

    assign alu_b = dx_i.ctrl.use_imm ? dx_i.imm : dx_i.b;

    alu i_main_alu (
        .data_a_i    (dx_i.a),
        .data_b_i    (alu_b),
        .alu_op_i    (dx_i.ctrl.alu_op),
        .shamt_i     (dx_i.ctrl.shamt),
        .result_o    (alu_val),
        .not_equal_o (),
        .less_than_o ()
    );

    // b - a, i.e. rd - rs
    alu i_compare_alu (
        .data_a_i    (dx_i.b),
        .data_b_i    (dx_i.a),
        .alu_op_i    (ALU_SUB),
        .shamt_i     (5'd0),
        .result_o    (),
        .not_equal_o (ne),
        .less_than_o (lt)
    );

    assign br_redirect_o = dx_i.ctrl.valid &
                           ((dx_i.ctrl.is_bne & ne) | (dx_i.ctrl.is_blt & lt));
    assign link_pc       = dx_i.pc + XLEN'(1);
    assign br_target_o   = link_pc + dx_i.imm;                // relative to pc+1

    assign result = dx_i.ctrl.is_jal ? link_pc : alu_val;

    // lw offers its address here, software keeps the next slot off its rd
    assign x_fwd_o = '{we:   dx_i.ctrl.valid & dx_i.ctrl.writes_reg,
                       rd:   dx_i.ctrl.rd,
                       data: result};

    always_comb begin
        xm_d            = '{ctrl: dx_i.ctrl, result: result, store_data: dx_i.b};
        xm_d.ctrl.valid = dx_i.ctrl.valid & ~br_redirect_o;    // taken branch is done here
    end

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) xm_q <= '0;
        else           xm_q <= xm_d;
    end

    assign xm_o = xm_q;

    // a redirect only comes from a live entry, and decode squashes the one behind it
    a_redirect_valid: assert property (@(posedge clock_i) disable iff (!arst_n_i)
        br_redirect_o |-> dx_i.ctrl.valid ##1 !dx_i.ctrl.valid)
        else $error("branch redirect from an invalid or unflushed entry");

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                      clock_i,
    input  logic                      arst_n_i,
    input  logic [cpu_pkg::XLEN-1:0]  insn_i,
    input  logic [cpu_pkg::XLEN-1:0]  pc_i,
    input  logic                      valid_i,
    output logic [cpu_pkg::REG_W-1:0] ctrl_readRegA_o,
    output logic [cpu_pkg::REG_W-1:0] ctrl_readRegB_o,
    input  logic [cpu_pkg::XLEN-1:0]  data_readRegA_i,
    input  logic [cpu_pkg::XLEN-1:0]  data_readRegB_i,
    input  cpu_pkg::fwd_t             x_fwd_i,       // youngest
    input  cpu_pkg::fwd_t             m_fwd_i,
    input  cpu_pkg::fwd_t             w_fwd_i,       // oldest, being written this cycle
    input  logic                      br_redirect_i,
    output logic                      jr_redirect_o,
    output logic [cpu_pkg::XLEN-1:0]  jr_target_o,
    output cpu_pkg::dx_t              dx_o
);
    import cpu_pkg::*;

    logic [4:0]       opcode;
    logic [REG_W-1:0] rd, rs, rt;
    logic             is_rtype, is_addi, is_lw, is_sw, is_bne, is_blt, is_jal, is_jr;
    logic [XLEN-1:0]  imm, op_a, op_b;
    ctrl_t            ctrl;
    dx_t              dx_d, dx_q;

    // youngest producer first, then the register file
    function automatic logic [XLEN-1:0] bypass(input logic [REG_W-1:0] idx,
                                               input logic [XLEN-1:0]  rf,
                                               input fwd_t x, input fwd_t m, input fwd_t w);
        logic [XLEN-1:0] val;
        val = rf;
        if (idx != '0) begin                     // r0 always reads the file
            if (x.we && x.rd == idx)      val = x.data;
            else if (m.we && m.rd == idx) val = m.data;
            else if (w.we && w.rd == idx) val = w.data;
        end
        return val;
    endfunction

    assign opcode = insn_i[OPC_HI:OPC_LO];
    assign rd     = insn_i[RD_HI:RD_LO];
    assign rs     = insn_i[RS_HI:RS_LO];
    assign rt     = insn_i[RT_HI:RT_LO];
    assign imm    = {{(XLEN-IMM_W){insn_i[IMM_W-1]}}, insn_i[IMM_W-1:0]};

    assign is_rtype = opcode == OP_RTYPE;
    assign is_addi  = opcode == OP_ADDI;
    assign is_lw    = opcode == OP_LW;
    assign is_sw    = opcode == OP_SW;
    assign is_bne   = opcode == OP_BNE;
    assign is_blt   = opcode == OP_BLT;
    assign is_jal   = opcode == OP_JAL;
    assign is_jr    = opcode == OP_JR;

    // jr target sits in rd, store data and branch operand in rd too
    assign ctrl_readRegA_o = is_jr ? rd : rs;
    assign ctrl_readRegB_o = (is_sw || is_bne || is_blt) ? rd : rt;

    assign op_a = bypass(ctrl_readRegA_o, data_readRegA_i, x_fwd_i, m_fwd_i, w_fwd_i);
    assign op_b = bypass(ctrl_readRegB_o, data_readRegB_i, x_fwd_i, m_fwd_i, w_fwd_i);

    always_comb begin
        ctrl.valid      = valid_i & ~br_redirect_i;          // squashed by a taken branch
        ctrl.rd         = is_jal ? REG_W'(LINK_REG) : rd;
        ctrl.writes_reg = (is_rtype | is_addi | is_lw | is_jal) && (ctrl.rd != '0);
        ctrl.alu_op     = is_rtype ? insn_i[ALU_HI:ALU_LO] : ALU_ADD;  // address and addi add
        ctrl.shamt      = insn_i[SHAMT_HI:SHAMT_LO];
        ctrl.use_imm    = is_addi | is_lw | is_sw;
        ctrl.is_lw      = is_lw;
        ctrl.is_sw      = is_sw;
        ctrl.is_bne     = is_bne;
        ctrl.is_blt     = is_blt;
        ctrl.is_jal     = is_jal;
        dx_d            = '{ctrl: ctrl, pc: pc_i, a: op_a, b: op_b, imm: imm};
    end

    assign jr_redirect_o = ctrl.valid & is_jr;
    assign jr_target_o   = op_a;                              // bypassed rd value

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) dx_q <= '0;
        else           dx_q <= dx_d;
    end

    assign dx_o = dx_q;

    // producers downstream never offer r0, so no bypass can come from it
    a_no_r0_bypass: assert property (@(posedge clock_i) disable iff (!arst_n_i)
        (!x_fwd_i.we || x_fwd_i.rd != '0) && (!m_fwd_i.we || m_fwd_i.rd != '0) &&
        (!w_fwd_i.we || w_fwd_i.rd != '0))
        else $error("write to r0 offered for bypass");

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                     clock_i,
    input  logic                     arst_n_i,
    input  logic [cpu_pkg::XLEN-1:0] q_imem_i,
    input  logic                     br_redirect_i,   // taken branch in execute
    input  logic [cpu_pkg::XLEN-1:0] br_target_i,
    input  logic                     jr_redirect_i,   // jr sitting in decode
    input  logic [cpu_pkg::XLEN-1:0] jr_target_i,
    output logic [cpu_pkg::XLEN-1:0] address_imem_o,
    output logic [cpu_pkg::XLEN-1:0] insn_o,
    output logic [cpu_pkg::XLEN-1:0] pc_o,
    output logic                     valid_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0] pc_q, pc_next;
    logic [XLEN-1:0] insn_q, fd_pc_q;            // fetch/decode payload
    logic            valid_q;
    logic [4:0]      opcode;
    logic            jump_seen;                  // j or jal in the word just fetched
    logic            flush;

    assign opcode    = q_imem_i[OPC_HI:OPC_LO];
    assign jump_seen = (opcode == OP_J) || (opcode == OP_JAL);
    assign flush     = br_redirect_i | jr_redirect_i;  // fetched word is on the wrong path

    // oldest redirect wins
    always_comb begin
        if (br_redirect_i)      pc_next = br_target_i;
        else if (jr_redirect_i) pc_next = jr_target_i;
        else if (jump_seen)     pc_next = {{(XLEN-TGT_W){1'b0}}, q_imem_i[TGT_W-1:0]};
        else                    pc_next = pc_q + XLEN'(1);
    end

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= '0;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= pc_next;
            valid_q <= ~flush;                   // a squashed slot travels as a bubble
        end
    end

    always_ff @(posedge clock_i) begin
        insn_q  <= q_imem_i;
        fd_pc_q <= pc_q;
    end

    assign address_imem_o = pc_q;
    assign insn_o         = insn_q;
    assign pc_o           = fd_pc_q;
    assign valid_o        = valid_q;

    // a branch resolving next to a predecoded jump must still steer the pc
    a_branch_over_jump: assert property (@(posedge clock_i) disable iff (!arst_n_i)
        (br_redirect_i && jump_seen) |=> (pc_q == $past(br_target_i)))
        else $error("fetch took jump target over branch target");

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [cpu_pkg::XLEN-1:0] data_a_i,
    input  logic [cpu_pkg::XLEN-1:0] data_b_i,
    input  logic [4:0]               alu_op_i,
    input  logic [4:0]               shamt_i,
    output logic [cpu_pkg::XLEN-1:0] result_o,
    output logic                     not_equal_o,
    output logic                     less_than_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0] diff;                       // a - b, shared by sub and the flags
    logic            sign_differs;

    assign diff         = data_a_i - data_b_i;
    assign sign_differs = data_a_i[XLEN-1] ^ data_b_i[XLEN-1];
    assign not_equal_o  = |diff;
    // with mixed signs a is smaller exactly when a is negative,
    // otherwise the difference cannot overflow and its sign decides
    assign less_than_o  = sign_differs ? data_a_i[XLEN-1] : diff[XLEN-1];

    always_comb begin
        case (alu_op_i)
            ALU_ADD: result_o = data_a_i + data_b_i;
            ALU_SUB: result_o = diff;
            ALU_AND: result_o = data_a_i & data_b_i;
            ALU_OR:  result_o = data_a_i | data_b_i;
            ALU_SLL: result_o = data_a_i << shamt_i;
            ALU_SRA: result_o = XLEN'($signed(data_a_i) >>> shamt_i);    // keeps sign
            default: result_o = '0;                                    // unused codes
        endcase
    end

endmodule

`default_nettype wire

// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN     = 32;        // data and address width
    localparam int REG_W    = 5;         // register index width
    localparam int LINK_REG = 31;        // jal return address lands here

    // opcodes, instruction bits 31..27
    localparam logic [4:0] OP_RTYPE = 5'd0;
    localparam logic [4:0] OP_J     = 5'd1;
    localparam logic [4:0] OP_BNE   = 5'd2;
    localparam logic [4:0] OP_JAL   = 5'd3;
    localparam logic [4:0] OP_JR    = 5'd4;
    localparam logic [4:0] OP_ADDI  = 5'd5;
    localparam logic [4:0] OP_BLT   = 5'd6;
    localparam logic [4:0] OP_SW    = 5'd7;
    localparam logic [4:0] OP_LW    = 5'd8;

    // alu codes, instruction bits 6..2 of r-type words
    localparam logic [4:0] ALU_ADD = 5'd0;
    localparam logic [4:0] ALU_SUB = 5'd1;
    localparam logic [4:0] ALU_AND = 5'd2;
    localparam logic [4:0] ALU_OR  = 5'd3;
    localparam logic [4:0] ALU_SLL = 5'd4;
    localparam logic [4:0] ALU_SRA = 5'd5;

    // instruction field positions
    localparam int OPC_HI   = 31;
    localparam int OPC_LO   = 27;
    localparam int RD_HI    = 26;
    localparam int RD_LO    = 22;
    localparam int RS_HI    = 21;
    localparam int RS_LO    = 17;
    localparam int RT_HI    = 16;
    localparam int RT_LO    = 12;
    localparam int SHAMT_HI = 11;
    localparam int SHAMT_LO = 7;
    localparam int ALU_HI   = 6;
    localparam int ALU_LO   = 2;
    localparam int IMM_W    = 17;        // sign-extended immediate
    localparam int TGT_W    = 27;        // zero-extended jump target

    // decoded once in decode, then carried down the pipe
    typedef struct packed {
        logic             valid;
        logic             writes_reg;    // already cleared for rd 0
        logic [REG_W-1:0] rd;
        logic [4:0]       alu_op;
        logic [4:0]       shamt;
        logic             use_imm;       // operand b is the immediate
        logic             is_lw;
        logic             is_sw;
        logic             is_bne;
        logic             is_blt;
        logic             is_jal;
    } ctrl_t;

    // a result offered for bypass and register write
    typedef struct packed {
        logic             we;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  data;
    } fwd_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] a;              // rs, or rd for jr
        logic [XLEN-1:0] b;              // rt, or rd for sw and branches
        logic [XLEN-1:0] imm;
    } dx_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] result;         // alu value, address or link
        logic [XLEN-1:0] store_data;
    } xm_t;

endpackage

`default_nettype wire
